//--- Makefile
# Verilator flow for the I/Q channel filter
TOP := iq_channel_filter_tb
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) \
		--Mdir $(OBJ) -o V$(TOP)
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)

//--- dv/iq_channel_filter_assert.sv
// concurrent checks on the power combiner's control outputs, bound into iq_power_combiner
`timescale 1ns/10ps

module iq_channel_filter_assert (
    input logic clk,
    input logic reset,
    input logic power_over,
    input logic out_valid
);

    // both flags leave a reset cycle low
    reset_clears_flags: assert property (
        @(posedge clk) reset |=> (!power_over && !out_valid)
    ) else $error("power_over or out_valid high after a reset cycle");

    // a full pipeline stays full until the next reset
    valid_holds: assert property (
        @(posedge clk) disable iff (reset)
        out_valid |=> out_valid
    ) else $error("out_valid fell without a reset");

    // the power flag only means something once the pipeline is full
    over_needs_valid: assert property (
        @(posedge clk) disable iff (reset)
        power_over |-> out_valid
    ) else $error("power_over high while out_valid is low");

endmodule

//--- dv/iq_channel_filter_tb.sv
// testbench for the I/Q channel filter, drives I/Q traffic and checks every output against a model
`timescale 1ns/10ps
`include "chanfilt_defines.svh"

module iq_channel_filter_tb;

    localparam int NBTAP  = `CHANFILT_NBTAP;
    localparam int RSHIFT = `CHANFILT_RSHIFT;
    localparam int FILL   = chanfilt_coef_pkg::FILL_CYCLES;
    localparam longint OUT_MAX = (longint'(1) << (`CHANFILT_OSIZE - 1)) - 1;
    localparam longint OUT_MIN = -(longint'(1) << (`CHANFILT_OSIZE - 1));

    // history depth must cover the whole filter span plus one combiner stage
    localparam int HLEN = 128;

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 10;
    localparam int IMPULSE_CYCLES = 120;
    localparam int RAND_CYCLES    = 1500;
    localparam int SAT_CYCLES     = 120;
    localparam int SWEEP_CYCLES   = 600;
    localparam int MIDRUN_CYCLES  = 200;
    localparam int MARGIN_CYCLES  = 200;

    localparam int TOTAL_CYCLES = 2 * RESET_CYCLES + 2 * FILL + 3 + IMPULSE_CYCLES
                                + RAND_CYCLES + 3 * SAT_CYCLES + SWEEP_CYCLES
                                + 2 * MIDRUN_CYCLES;
    localparam int WATCHDOG_NS = (TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    localparam chanfilt_types_pkg::sample_t SMAX = 16'sh7fff;
    localparam chanfilt_types_pkg::sample_t SMIN = 16'sh8000;

    logic                        clk;
    logic                        reset;
    chanfilt_types_pkg::sample_t i_in;
    chanfilt_types_pkg::sample_t q_in;
    chanfilt_types_pkg::power_t  power_threshold;
    chanfilt_types_pkg::out_t    i_out;
    chanfilt_types_pkg::out_t    q_out;
    chanfilt_types_pkg::power_t  power;
    logic                        power_over;
    logic                        out_valid;

    int     seed = 64859;
    int     edge_cnt = 0;
    int     low_cnt = 0;
    int     sat_hits = 0;
    longint hist_i[HLEN];
    longint hist_q[HLEN];

    iq_channel_filter_top dut_i (
        .clk            (clk),
        .reset          (reset),
        .i_in           (i_in),
        .q_in           (q_in),
        .power_threshold(power_threshold),
        .i_out          (i_out),
        .q_out          (q_out),
        .power          (power),
        .power_over     (power_over),
        .out_valid      (out_valid)
    );

    bind iq_power_combiner iq_channel_filter_assert assert_i (
        .clk       (clk),
        .reset     (reset),
        .power_over(power_over),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic signed [63:0] got,
                               input logic signed [63:0] expected);
        if (got !== expected) begin
            report_failure($sformatf("FAILED at %0d ns: %s is %0d, expected %0d",
                                     $time, name, got, expected));
        end
    endtask

    // samples before the first clock edge count as zero
    function automatic longint sample_at(input bit q_chan, input int idx);
        if (idx < 1) begin
            return 0;
        end
        return q_chan ? hist_q[idx % HLEN] : hist_i[idx % HLEN];
    endfunction

    // filter sum seen by the combiner at edge e, wrapped to the accumulator width
    function automatic longint filter_sum(input bit q_chan, input int e);
        longint                            sum;
        logic signed [`CHANFILT_PSIZE-1:0] wrapped;
        sum = 0;
        for (int k = 0; k < NBTAP; k++) begin
            sum += longint'(chanfilt_coef_pkg::COEF[k])
                 * (sample_at(q_chan, e - NBTAP - 4 - k)
                    + sample_at(q_chan, e - 3 * NBTAP - 3 + k));
        end
        wrapped = sum[`CHANFILT_PSIZE-1:0];
        return longint'(wrapped);
    endfunction

    // round half up, arithmetic shift, clip to the output range
    function automatic longint round_clip(input longint acc);
        longint r;
        r = (acc + (longint'(1) << (RSHIFT - 1))) >>> RSHIFT;
        if (r > OUT_MAX) begin
            r = OUT_MAX;
        end else if (r < OUT_MIN) begin
            r = OUT_MIN;
        end
        return r;
    endfunction

    // power registered at edge e comes from the rounded outputs of edge e-1
    function automatic longint expected_power(input int e);
        longint pi;
        longint pq;
        pi = round_clip(filter_sum(1'b0, e - 1));
        pq = round_clip(filter_sum(1'b1, e - 1));
        return pi * pi + pq * pq;
    endfunction

    function automatic void reference_model(input int e, input longint thr, input bit gate,
                                            output longint i_e, output longint q_e,
                                            output longint p_e, output bit over_e);
        i_e    = round_clip(filter_sum(1'b0, e));
        q_e    = round_clip(filter_sum(1'b1, e));
        p_e    = expected_power(e);
        over_e = gate && (p_e > thr);
    endfunction

    function automatic chanfilt_types_pkg::sample_t random_sample();
        return chanfilt_types_pkg::sample_t'($random(seed));
    endfunction

    // spread over the range that typical power values reach
    function automatic chanfilt_types_pkg::power_t random_threshold();
        return chanfilt_types_pkg::power_t'($unsigned($random(seed)) >> 1);
    endfunction

    task automatic drive_inputs(input chanfilt_types_pkg::sample_t i_val,
                                input chanfilt_types_pkg::sample_t q_val,
                                input chanfilt_types_pkg::power_t thr);
        @(negedge clk);
        i_in            = i_val;
        q_in            = q_val;
        power_threshold = thr;
    endtask

    task automatic wait_for_valid(input int limit);
        int n;
        n = 0;
        while (out_valid !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (out_valid !== 1'b1) begin
            report_failure($sformatf("out_valid still low after %0d cycles", limit));
        end
    endtask

    // records what the DUT samples on each edge, then checks the settled outputs
    initial begin : compare_proc
        bit     rst_s;
        bit     valid_before;
        bit     exp_valid;
        bit     over_e;
        longint thr_s;
        longint i_e;
        longint q_e;
        longint p_e;
        forever begin
            @(posedge clk);
            rst_s = reset;
            thr_s = longint'(power_threshold);
            edge_cnt++;
            hist_i[edge_cnt % HLEN] = longint'(i_in);
            hist_q[edge_cnt % HLEN] = longint'(q_in);
            valid_before = (low_cnt == FILL);
            if (rst_s) begin
                low_cnt = 0;
            end else if (low_cnt < FILL) begin
                low_cnt++;
            end
            exp_valid = (low_cnt == FILL);
            reference_model(edge_cnt, thr_s, !rst_s && valid_before, i_e, q_e, p_e, over_e);
            if (exp_valid && (i_e == OUT_MAX || i_e == OUT_MIN
                              || q_e == OUT_MAX || q_e == OUT_MIN)) begin
                sat_hits++;
            end
            #1;
            check_value("out_valid", out_valid, exp_valid);
            check_value("power_over", power_over, over_e);
            if (exp_valid) begin
                check_value("i_out", i_out, i_e);
                check_value("q_out", q_out, q_e);
                check_value("power", power, p_e);
            end
        end
    end

    initial begin : stimulus_proc
        int                         pick;
        chanfilt_types_pkg::power_t thr;
        reset           = 1'b1;
        i_in            = '0;
        q_in            = '0;
        power_threshold = '1;
        thr             = '1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        wait_for_valid(FILL + 2);

        // single full-scale impulse on I, Q held at zero
        drive_inputs(SMAX, '0, thr);
        repeat (IMPULSE_CYCLES) drive_inputs('0, '0, thr);

        // independent random streams, threshold moves every 16 samples
        for (int n = 0; n < RAND_CYCLES; n++) begin
            if (n % 16 == 0) begin
                thr = random_threshold();
            end
            drive_inputs(random_sample(), random_sample(), thr);
        end

        // DC gain is above one, so full-scale constants and a slow square wave clip
        sat_hits = 0;
        repeat (SAT_CYCLES) drive_inputs(SMAX, SMIN, thr);
        for (int n = 0; n < SAT_CYCLES; n++) begin
            drive_inputs(((n / 32) % 2) ? SMIN : SMAX, ((n / 32) % 2) ? SMAX : SMIN, thr);
        end
        repeat (SAT_CYCLES) drive_inputs(SMIN, SMAX, thr);
        if (sat_hits == 0) begin
            report_failure("saturation inputs never drove the outputs to their limits");
        end

        // threshold placed on, just below and just above the coming power value
        for (int n = 0; n < SWEEP_CYCLES; n++) begin
            @(negedge clk);
            i_in = random_sample();
            q_in = random_sample();
            pick = $random(seed) & 3;
            case (pick)
                0: power_threshold = chanfilt_types_pkg::power_t'(expected_power(edge_cnt + 1));
                1: power_threshold = chanfilt_types_pkg::power_t'(expected_power(edge_cnt + 1) - 1);
                2: power_threshold = chanfilt_types_pkg::power_t'(expected_power(edge_cnt + 1) + 1);
                default: power_threshold = random_threshold();
            endcase
        end

        // reset in the middle of traffic, data keeps flowing through the filter
        repeat (MIDRUN_CYCLES) drive_inputs(random_sample(), random_sample(), random_threshold());
        for (int n = 0; n < RESET_CYCLES + FILL + MIDRUN_CYCLES; n++) begin
            drive_inputs(random_sample(), random_sample(), random_threshold());
            reset = (n < RESET_CYCLES);
        end
        wait_for_valid(0);

        @(negedge clk);
        $display("sim passed");
        $finish;
    end

    initial begin : watchdog_proc
        #(WATCHDOG_NS);
        report_failure("timed out before all test phases finished");
    end

endmodule

//--- rtl/chanfilt_coef_pkg.sv
// half coefficient table and latency constants of the 56-tap symmetric channel filter
`include "chanfilt_defines.svh"

package chanfilt_coef_pkg;

    // entry 0 is the outermost pair, the last entry sits next to the centre
    localparam chanfilt_types_pkg::coef_t COEF[`CHANFILT_NBTAP] = '{
        18'sd560, 18'sd608, -18'sd120, -18'sd354,
        -18'sd34, 18'sd538, 18'sd40, -18'sd560,
        -18'sd250, 18'sd692, 18'sd412, -18'sd710,
        -18'sd704, 18'sd740, 18'sd1014, -18'sd662,
        -18'sd1436, 18'sd514, 18'sd1936, -18'sd198,
        -18'sd2608, -18'sd354, 18'sd3572, 18'sd1438,
        -18'sd5354, -18'sd4176, 18'sd11198, 18'sd27938
    };

    // first cycle at which an input sample reaches firout
    localparam int FIR_FIRST = `CHANFILT_NBTAP + 4;

    // last cycle at which the same sample still contributes
    localparam int FIR_LAST = 3 * `CHANFILT_NBTAP + 3;

    // filter span plus the two combiner stages
    localparam int FILL_CYCLES = FIR_LAST + 2;

endpackage

//--- rtl/chanfilt_defines.svh
// size and tap-count macros for the I/Q channel filter, included by the packages and the RTL
`ifndef CHANFILT_DEFINES_SVH
`define CHANFILT_DEFINES_SVH

// number of coefficient pairs, the filter has twice as many taps
`define CHANFILT_NBTAP 28

// input sample and coefficient widths
`define CHANFILT_DSIZE 16
`define CHANFILT_CSIZE 18

// cascade accumulator width, wraps at this size
`define CHANFILT_PSIZE 34

// combiner output sample width, rounding shift and power width
`define CHANFILT_OSIZE 16
`define CHANFILT_RSHIFT 15
`define CHANFILT_WSIZE 33

`endif

//--- rtl/chanfilt_types_pkg.sv
// datapath word types shared by the symmetric FIR, the power combiner and the testbench
`include "chanfilt_defines.svh"

package chanfilt_types_pkg;

    // one input sample from the I or Q stream
    typedef logic signed [`CHANFILT_DSIZE-1:0] sample_t;

    // filter coefficient
    typedef logic signed [`CHANFILT_CSIZE-1:0] coef_t;

    // sum of the forward and mirrored samples, one bit wider than a sample
    typedef logic signed [`CHANFILT_DSIZE:0] preadd_t;

    // product and cascade sum, modulo 2^PSIZE
    typedef logic signed [`CHANFILT_PSIZE-1:0] acc_t;

    // rounded and saturated filter output
    typedef logic signed [`CHANFILT_OSIZE-1:0] out_t;

    // I^2 + Q^2, never negative
    typedef logic [`CHANFILT_WSIZE-1:0] power_t;

endpackage

//--- rtl/iq_channel_filter_top.sv
// receive channel filter top: I and Q symmetric FIRs feeding the power combiner
`timescale 1ns/10ps

module iq_channel_filter_top (
    input  logic                        clk,
    input  logic                        reset,
    input  chanfilt_types_pkg::sample_t i_in,
    input  chanfilt_types_pkg::sample_t q_in,
    input  chanfilt_types_pkg::power_t  power_threshold,
    output chanfilt_types_pkg::out_t    i_out,
    output chanfilt_types_pkg::out_t    q_out,
    output chanfilt_types_pkg::power_t  power,
    output logic                        power_over,
    output logic                        out_valid
);

    // raw filter sums, one per channel
    chanfilt_types_pkg::acc_t i_acc;
    chanfilt_types_pkg::acc_t q_acc;

    sfir_even_symmetric_systolic i_fir (
        .clk   (clk),
        .datain(i_in),
        .firout(i_acc)
    );

    sfir_even_symmetric_systolic q_fir (
        .clk   (clk),
        .datain(q_in),
        .firout(q_acc)
    );

    iq_power_combiner combiner_i (
        .clk            (clk),
        .reset          (reset),
        .i_acc          (i_acc),
        .q_acc          (q_acc),
        .power_threshold(power_threshold),
        .i_out          (i_out),
        .q_out          (q_out),
        .power          (power),
        .power_over     (power_over),
        .out_valid      (out_valid)
    );

endmodule

//--- rtl/iq_power_combiner.sv
// rounds and saturates the I and Q filter sums, computes I^2+Q^2 and flags it above threshold
`timescale 1ns/10ps
`include "chanfilt_defines.svh"

module iq_power_combiner (
    input  logic                        clk,
    input  logic                        reset,
    input  chanfilt_types_pkg::acc_t    i_acc,
    input  chanfilt_types_pkg::acc_t    q_acc,
    input  chanfilt_types_pkg::power_t  power_threshold,
    output chanfilt_types_pkg::out_t    i_out,
    output chanfilt_types_pkg::out_t    q_out,
    output chanfilt_types_pkg::power_t  power,
    output logic                        power_over,
    output logic                        out_valid
);

    localparam int PSIZE  = `CHANFILT_PSIZE;
    localparam int OSIZE  = `CHANFILT_OSIZE;
    localparam int RSHIFT = `CHANFILT_RSHIFT;
    localparam int WSIZE  = `CHANFILT_WSIZE;

    // width left after the shift, one guard bit from the rounding add
    localparam int SW = PSIZE - RSHIFT + 1;

    // half an LSB of the output, at accumulator width plus one
    localparam logic signed [PSIZE:0] ROUND_BIAS =
        {{(PSIZE - RSHIFT + 1){1'b0}}, 1'b1, {(RSHIFT - 1){1'b0}}};

    // out_t limits at the shifted width
    localparam logic signed [SW-1:0] SAT_MAX = {{(SW - OSIZE + 1){1'b0}}, {(OSIZE - 1){1'b1}}};
    localparam logic signed [SW-1:0] SAT_MIN = {{(SW - OSIZE + 1){1'b1}}, {(OSIZE - 1){1'b0}}};

    localparam int CNT_W = $clog2(chanfilt_coef_pkg::FILL_CYCLES + 1);
    localparam logic [CNT_W-1:0] FILL_END = CNT_W'(chanfilt_coef_pkg::FILL_CYCLES);

    typedef logic signed [WSIZE-1:0] sq_t;

    logic [CNT_W-1:0]           fill_cnt;
    chanfilt_types_pkg::power_t power_next;

    // round half up, arithmetic shift, then clip to the out_t range
    function automatic chanfilt_types_pkg::out_t round_sat(input chanfilt_types_pkg::acc_t acc);
        logic signed [PSIZE:0]  biased;
        logic signed [SW-1:0]   shifted;
        chanfilt_types_pkg::out_t result;
        biased  = {acc[PSIZE-1], acc} + ROUND_BIAS;
        shifted = biased[PSIZE:RSHIFT];
        if (shifted > SAT_MAX) begin
            result = SAT_MAX[OSIZE-1:0];
        end else if (shifted < SAT_MIN) begin
            result = SAT_MIN[OSIZE-1:0];
        end else begin
            result = shifted[OSIZE-1:0];
        end
        return result;
    endfunction

    // stage 1: rounded outputs, no reset on payload
    always_ff @(posedge clk) begin
        i_out <= round_sat(i_acc);
        q_out <= round_sat(q_acc);
    end

    // squares of 16-bit values fit easily, the sum is never negative
    assign power_next = chanfilt_types_pkg::power_t'(sq_t'(i_out) * sq_t'(i_out)
                                                   + sq_t'(q_out) * sq_t'(q_out));

    // stage 2: power and the threshold flag
    always_ff @(posedge clk) begin
        power <= power_next;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            power_over <= 1'b0;
        end else begin
            power_over <= (power_next > power_threshold) && out_valid;
        end
    end

    // counts the cycles since reset until the filter and both stages hold real data
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_cnt <= '0;
        end else if (fill_cnt != FILL_END) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    assign out_valid = (fill_cnt == FILL_END);

endmodule

//--- rtl/sfir_even_symmetric_systolic.sv
// complete 56-tap even-symmetric systolic FIR, one sample in and one sum out per clock
`timescale 1ns/10ps
`include "chanfilt_defines.svh"

module sfir_even_symmetric_systolic (
    input  logic                        clk,
    input  chanfilt_types_pkg::sample_t datain,
    output chanfilt_types_pkg::acc_t    firout
);

    localparam int NBTAP = `CHANFILT_NBTAP;

    // mirrored sample, shared by all taps
    chanfilt_types_pkg::sample_t shifterout;

    // forward data chain, entry k feeds tap k
    chanfilt_types_pkg::sample_t fwd_data[NBTAP+1];

    // cascade chain, entry k is the partial sum entering tap k
    chanfilt_types_pkg::acc_t casc_sum[NBTAP+1];

    assign fwd_data[0] = datain;
    assign casc_sum[0] = '0;

    // the last tap's forward output leaves the array here
    // and the full sum of all taps is the filter output
    assign firout = casc_sum[NBTAP];

    sfir_shifter shifter_i (
        .clk    (clk),
        .datain (datain),
        .dataout(shifterout)
    );

    // tap k pairs x(t-NBTAP-4-k) with x(t-3*NBTAP-3+k) at the output,
    // so the outermost pair uses entry 0 of the table
    for (genvar k = 0; k < NBTAP; k++) begin : g_tap
        sfir_even_symmetric_systolic_element tap_i (
            .clk     (clk),
            .coeffin (chanfilt_coef_pkg::COEF[k]),
            .datain  (fwd_data[k]),
            .datazin (shifterout),
            .cascin  (casc_sum[k]),
            .cascdata(fwd_data[k+1]),
            .cascout (casc_sum[k+1])
        );
    end

endmodule

//--- rtl/sfir_even_symmetric_systolic_element.sv
// one tap of the systolic symmetric FIR: pre-add, multiply and cascade add
`timescale 1ns/10ps

module sfir_even_symmetric_systolic_element (
    input  logic                        clk,
    input  chanfilt_types_pkg::coef_t   coeffin,
    input  chanfilt_types_pkg::sample_t datain,
    input  chanfilt_types_pkg::sample_t datazin,
    input  chanfilt_types_pkg::acc_t    cascin,
    output chanfilt_types_pkg::sample_t cascdata,
    output chanfilt_types_pkg::acc_t    cascout
);

    chanfilt_types_pkg::coef_t   coeff;
    chanfilt_types_pkg::sample_t data;
    chanfilt_types_pkg::sample_t datatwo;
    chanfilt_types_pkg::sample_t dataz;
    chanfilt_types_pkg::preadd_t preadd;
    chanfilt_types_pkg::acc_t    product;

    // forward data moves two registers per tap, the mirrored sample only one
    assign cascdata = datatwo;

    always_ff @(posedge clk) begin
        coeff   <= coeffin;
        data    <= datain;
        datatwo <= data;
        dataz   <= datazin;
        // both samples sign extended before the add
        preadd  <= chanfilt_types_pkg::preadd_t'(datatwo)
                 + chanfilt_types_pkg::preadd_t'(dataz);
        // product kept at accumulator width, so it wraps like the cascade
        product <= chanfilt_types_pkg::acc_t'(preadd)
                 * chanfilt_types_pkg::acc_t'(coeff);
        cascout <= product + cascin;
    end

endmodule

//--- rtl/sfir_shifter.sv
// long delay line of the symmetric FIR, supplies the mirrored sample to every tap
`timescale 1ns/10ps
`include "chanfilt_defines.svh"

module sfir_shifter (
    input  logic                        clk,
    input  chanfilt_types_pkg::sample_t datain,
    output chanfilt_types_pkg::sample_t dataout
);

    localparam int DEPTH = 2 * `CHANFILT_NBTAP;

    // plain shift chain, no reset and no enable so it packs into SRLs
    chanfilt_types_pkg::sample_t stage[DEPTH];

    always_ff @(posedge clk) begin
        stage[0] <= datain;
        for (int i = 1; i < DEPTH; i++) begin
            stage[i] <= stage[i-1];
        end
    end

    // input delayed by 2*NBTAP cycles
    assign dataout = stage[DEPTH-1];

endmodule

//--- vlog.f
+incdir+rtl
rtl/chanfilt_types_pkg.sv
rtl/chanfilt_coef_pkg.sv
rtl/sfir_shifter.sv
rtl/sfir_even_symmetric_systolic_element.sv
rtl/sfir_even_symmetric_systolic.sv
rtl/iq_power_combiner.sv
rtl/iq_channel_filter_top.sv
dv/iq_channel_filter_assert.sv
dv/iq_channel_filter_tb.sv
